/* capture_params.svh */
`ifndef CAPTURE_PARAMS_SVH
`define CAPTURE_PARAMS_SVH

// Frame geometry in pixels
`define FRAME_WIDTH  16
`define FRAME_HEIGHT 4

// Word address where each channel's frame buffer starts
`define CH0_BASE 0
`define CH1_BASE 64

// Shared frame memory size in 16-bit words
`define RAM_DEPTH 128

`endif

/* wb_pkg.sv */
package wb_pkg;

	// Word address and data of the shared bus
	typedef logic [6:0]  wb_addr_t;
	typedef logic [15:0] wb_data_t;

	// Arbiter master index
	typedef logic [1:0] master_idx_t;

	localparam int NUM_MASTERS = 3;

	localparam master_idx_t MST_CH0  = 2'd0;
	localparam master_idx_t MST_CH1  = 2'd1;
	localparam master_idx_t MST_HOST = 2'd2;

endpackage

/* video_pkg.sv */
package video_pkg;

	// Channel 0 format, one luma sample
	typedef logic [7:0] gray_t;

	// Channel 1 format, red in the top bits
	typedef struct packed {
		logic [4:0] r;
		logic [5:0] g;
		logic [4:0] b;
	} rgb565_t;

endpackage

/* axis_relay.sv */
module axis_relay #(
	parameter type payload_t = logic [7:0]
) (
	input  logic     clk,
	input  logic     resetn,

	input  logic     s_valid,
	input  payload_t s_data,
	input  logic     s_user,
	input  logic     s_last,
	output logic     s_ready,

	output logic     m_valid,
	output payload_t m_data,
	output logic     m_user,
	output logic     m_last,
	input  logic     m_ready
);

	// Output stage and skid stage
	logic     out_valid;
	payload_t out_data;
	logic     out_user;
	logic     out_last;

	logic     skid_valid;
	payload_t skid_data;
	logic     skid_user;
	logic     skid_last;

	logic accept;
	logic out_free;

	assign accept   = s_valid && s_ready;
	// Output register can take a new entry this cycle
	assign out_free = !out_valid || m_ready;

	assign m_valid = out_valid;
	assign m_data  = out_data;
	assign m_user  = out_user;
	assign m_last  = out_last;

	//////////////////////////////////////////////////
	// Occupancy

	always_ff @(posedge clk) begin
		if (!resetn) begin
			out_valid  <= 1'b0;
			skid_valid <= 1'b0;
		end else begin
			if (out_free)
				out_valid <= skid_valid || accept;
			// Catches the pixel taken while ready was still high
			if (accept && !out_free)
				skid_valid <= 1'b1;
			else if (out_free)
				skid_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (out_free) begin
			if (skid_valid) begin
				out_data <= skid_data;
				out_user <= skid_user;
				out_last <= skid_last;
			end else if (accept) begin
				out_data <= s_data;
				out_user <= s_user;
				out_last <= s_last;
			end
		end
		if (accept && !out_free) begin
			skid_data <= s_data;
			skid_user <= s_user;
			skid_last <= s_last;
		end
	end

	//////////////////////////////////////////////////
	// Registered ready

	always_ff @(posedge clk) begin
		if (!resetn) begin
			s_ready <= 1'b0;
		end else begin
			case ({skid_valid, out_valid})
				2'b00, 2'b10: s_ready <= 1'b1;
				2'b01:        s_ready <= m_ready;
				default:      s_ready <= 1'b0;
			endcase
		end
	end

endmodule

/* frame_writer.sv */
`include "capture_params.svh"

module frame_writer import wb_pkg::*; #(
	parameter type      pixel_t   = logic [7:0],
	parameter wb_addr_t base_addr = '0
) (
	input  logic     clk,
	input  logic     resetn,

	input  logic     s_valid,
	input  pixel_t   s_data,
	input  logic     s_user,
	input  logic     s_last,
	output logic     s_ready,

	output logic     wb_cyc,
	output logic     wb_stb,
	output logic     wb_we,
	output wb_addr_t wb_adr,
	output wb_data_t wb_dat_w,
	input  logic     wb_ack,

	output logic     frame_done,
	output logic     line_error
);

	localparam int COL_W  = $clog2(`FRAME_WIDTH);
	localparam int LINE_W = $clog2(`FRAME_HEIGHT);

	logic [COL_W-1:0]  col;
	logic [LINE_W-1:0] line;
	logic [COL_W-1:0]  col_cur;
	logic [LINE_W-1:0] line_cur;

	logic [$bits(pixel_t)-1:0] pix_bits;
	wb_addr_t pix_adr;
	logic accept;
	logic last_of_frame;
	logic bad_line;

	assign accept = s_valid && s_ready;
	assign s_ready = !wb_cyc;

	// A start-of-frame pixel is always column 0 of line 0
	assign col_cur  = s_user ? '0 : col;
	assign line_cur = s_user ? '0 : line;

	assign pix_bits = s_data;
	assign pix_adr  = base_addr + wb_addr_t'(line_cur) * wb_addr_t'(`FRAME_WIDTH)
		+ wb_addr_t'(col_cur);

	// tlast must land on the final column and nowhere else
	assign bad_line = s_last != (col_cur == COL_W'(`FRAME_WIDTH - 1));

	assign wb_stb = wb_cyc;
	assign wb_we  = 1'b1;

	//////////////////////////////////////////////////
	// Position and bus cycle

	always_ff @(posedge clk) begin
		if (!resetn) begin
			col           <= '0;
			line          <= '0;
			wb_cyc        <= 1'b0;
			last_of_frame <= 1'b0;
			frame_done    <= 1'b0;
			line_error    <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			if (accept) begin
				wb_cyc        <= 1'b1;
				last_of_frame <= s_last && (line_cur == LINE_W'(`FRAME_HEIGHT - 1));
				if (s_last) begin
					col  <= '0;
					line <= line_cur + 1'b1;
				end else begin
					col  <= col_cur + 1'b1;
					line <= line_cur;
				end
				if (bad_line)
					line_error <= 1'b1;
				else if (s_user)
					line_error <= 1'b0;
			end else if (wb_cyc && wb_ack) begin
				wb_cyc     <= 1'b0;
				frame_done <= last_of_frame;
			end
		end
	end

	// Write payload, zero-extended pixel
	always_ff @(posedge clk) begin
		if (accept) begin
			wb_adr   <= pix_adr;
			wb_dat_w <= wb_data_t'(pix_bits);
		end
	end

endmodule

/* wb_arbiter.sv */
module wb_arbiter import wb_pkg::*; (
	input  logic                       clk,
	input  logic                       resetn,

	input  logic     [NUM_MASTERS-1:0] m_cyc,
	input  logic     [NUM_MASTERS-1:0] m_stb,
	input  logic     [NUM_MASTERS-1:0] m_we,
	input  wb_addr_t [NUM_MASTERS-1:0] m_adr,
	input  wb_data_t [NUM_MASTERS-1:0] m_dat_w,
	output wb_data_t [NUM_MASTERS-1:0] m_dat_r,
	output logic     [NUM_MASTERS-1:0] m_ack,

	output logic                       s_cyc,
	output logic                       s_stb,
	output logic                       s_we,
	output wb_addr_t                   s_adr,
	output wb_data_t                   s_dat_w,
	input  wb_data_t                   s_dat_r,
	input  logic                       s_ack
);

	master_idx_t owner;
	logic        busy;

	// First requester after the last owner, in ring order
	function automatic master_idx_t pick_next(master_idx_t last,
		logic [NUM_MASTERS-1:0] req);
		master_idx_t pick;
		int idx;
		pick = last;
		for (int i = NUM_MASTERS; i >= 1; i--) begin
			idx = (int'(last) + i) % NUM_MASTERS;
			if (req[idx])
				pick = master_idx_t'(idx);
		end
		return pick;
	endfunction

	always_ff @(posedge clk) begin
		if (!resetn) begin
			busy  <= 1'b0;
			owner <= MST_HOST;
		end else if (!busy) begin
			if (|m_cyc) begin
				busy  <= 1'b1;
				owner <= pick_next(owner, m_cyc);
			end
		end else if (!m_cyc[owner]) begin
			busy <= 1'b0;
		end
	end

	//////////////////////////////////////////////////
	// Owner's request to the slave

	assign s_cyc   = busy && m_cyc[owner];
	assign s_stb   = busy && m_stb[owner];
	assign s_we    = m_we[owner];
	assign s_adr   = m_adr[owner];
	assign s_dat_w = m_dat_w[owner];

	// Responses only reach the owner
	always_comb begin
		for (int i = 0; i < NUM_MASTERS; i++) begin
			m_ack[i]   = busy && (owner == master_idx_t'(i)) && s_ack;
			m_dat_r[i] = (busy && owner == master_idx_t'(i)) ? s_dat_r : '0;
		end
	end

endmodule

/* frame_ram.sv */
`include "capture_params.svh"

module frame_ram import wb_pkg::*; (
	input  logic     clk,
	input  logic     resetn,

	input  logic     cyc,
	input  logic     stb,
	input  logic     we,
	input  wb_addr_t adr,
	input  wb_data_t dat_w,
	output wb_data_t dat_r,
	output logic     ack
);

	wb_data_t mem [`RAM_DEPTH];

	logic access;

	// A held strobe is served once, ack drops the cycle after
	assign access = cyc && stb && !ack;

	always_ff @(posedge clk) begin
		if (!resetn)
			ack <= 1'b0;
		else
			ack <= access;
	end

	// Storage and registered read data
	always_ff @(posedge clk) begin
		if (access) begin
			if (we)
				mem[adr] <= dat_w;
			dat_r <= mem[adr];
		end
	end

endmodule

/* frame_capture.sv */
`include "capture_params.svh"

module frame_capture import video_pkg::*, wb_pkg::*; (
	input  logic     clk,
	input  logic     resetn,

	input  logic     ch0_valid,
	input  gray_t    ch0_data,
	input  logic     ch0_user,
	input  logic     ch0_last,
	output logic     ch0_ready,

	input  logic     ch1_valid,
	input  rgb565_t  ch1_data,
	input  logic     ch1_user,
	input  logic     ch1_last,
	output logic     ch1_ready,

	input  logic     host_cyc,
	input  logic     host_stb,
	input  logic     host_we,
	input  wb_addr_t host_adr,
	input  wb_data_t host_dat_w,
	output wb_data_t host_dat_r,
	output logic     host_ack,

	output logic     ch0_frame_done,
	output logic     ch1_frame_done,
	output logic     ch0_line_error,
	output logic     ch1_line_error
);

	// Relay outputs into the writers
	logic    r0_valid, r0_user, r0_last, r0_ready;
	gray_t   r0_data;
	logic    r1_valid, r1_user, r1_last, r1_ready;
	rgb565_t r1_data;

	// Master side of the arbiter
	logic     [NUM_MASTERS-1:0] bus_cyc;
	logic     [NUM_MASTERS-1:0] bus_stb;
	logic     [NUM_MASTERS-1:0] bus_we;
	wb_addr_t [NUM_MASTERS-1:0] bus_adr;
	wb_data_t [NUM_MASTERS-1:0] bus_dat_w;
	wb_data_t [NUM_MASTERS-1:0] bus_dat_r;
	logic     [NUM_MASTERS-1:0] bus_ack;

	// Slave side
	logic     ram_cyc, ram_stb, ram_we, ram_ack;
	wb_addr_t ram_adr;
	wb_data_t ram_dat_w, ram_dat_r;

	//////////////////////////////////////////////////
	// Channel 0, grayscale

	axis_relay #(.payload_t(gray_t)) i_relay0 (
		.clk(clk), .resetn(resetn),
		.s_valid(ch0_valid), .s_data(ch0_data), .s_user(ch0_user),
		.s_last(ch0_last), .s_ready(ch0_ready),
		.m_valid(r0_valid), .m_data(r0_data), .m_user(r0_user),
		.m_last(r0_last), .m_ready(r0_ready)
	);

	frame_writer #(.pixel_t(gray_t), .base_addr(wb_addr_t'(`CH0_BASE))) i_writer0 (
		.clk(clk), .resetn(resetn),
		.s_valid(r0_valid), .s_data(r0_data), .s_user(r0_user),
		.s_last(r0_last), .s_ready(r0_ready),
		.wb_cyc(bus_cyc[MST_CH0]), .wb_stb(bus_stb[MST_CH0]), .wb_we(bus_we[MST_CH0]),
		.wb_adr(bus_adr[MST_CH0]), .wb_dat_w(bus_dat_w[MST_CH0]),
		.wb_ack(bus_ack[MST_CH0]),
		.frame_done(ch0_frame_done), .line_error(ch0_line_error)
	);

	//////////////////////////////////////////////////
	// Channel 1, RGB565

	axis_relay #(.payload_t(rgb565_t)) i_relay1 (
		.clk(clk), .resetn(resetn),
		.s_valid(ch1_valid), .s_data(ch1_data), .s_user(ch1_user),
		.s_last(ch1_last), .s_ready(ch1_ready),
		.m_valid(r1_valid), .m_data(r1_data), .m_user(r1_user),
		.m_last(r1_last), .m_ready(r1_ready)
	);

	frame_writer #(.pixel_t(rgb565_t), .base_addr(wb_addr_t'(`CH1_BASE))) i_writer1 (
		.clk(clk), .resetn(resetn),
		.s_valid(r1_valid), .s_data(r1_data), .s_user(r1_user),
		.s_last(r1_last), .s_ready(r1_ready),
		.wb_cyc(bus_cyc[MST_CH1]), .wb_stb(bus_stb[MST_CH1]), .wb_we(bus_we[MST_CH1]),
		.wb_adr(bus_adr[MST_CH1]), .wb_dat_w(bus_dat_w[MST_CH1]),
		.wb_ack(bus_ack[MST_CH1]),
		.frame_done(ch1_frame_done), .line_error(ch1_line_error)
	);

	//////////////////////////////////////////////////
	// Host port, arbiter and memory

	assign bus_cyc[MST_HOST]   = host_cyc;
	assign bus_stb[MST_HOST]   = host_stb;
	assign bus_we[MST_HOST]    = host_we;
	assign bus_adr[MST_HOST]   = host_adr;
	assign bus_dat_w[MST_HOST] = host_dat_w;
	assign host_dat_r          = bus_dat_r[MST_HOST];
	assign host_ack            = bus_ack[MST_HOST];

	wb_arbiter i_arbiter (
		.clk(clk), .resetn(resetn),
		.m_cyc(bus_cyc), .m_stb(bus_stb), .m_we(bus_we), .m_adr(bus_adr),
		.m_dat_w(bus_dat_w), .m_dat_r(bus_dat_r), .m_ack(bus_ack),
		.s_cyc(ram_cyc), .s_stb(ram_stb), .s_we(ram_we), .s_adr(ram_adr),
		.s_dat_w(ram_dat_w), .s_dat_r(ram_dat_r), .s_ack(ram_ack)
	);

	frame_ram i_ram (
		.clk(clk), .resetn(resetn),
		.cyc(ram_cyc), .stb(ram_stb), .we(ram_we), .adr(ram_adr),
		.dat_w(ram_dat_w), .dat_r(ram_dat_r), .ack(ram_ack)
	);

endmodule

/* tb_clock.sv */
module tb_clock #(
	parameter int period_ns = 40
) (
	output logic clk
);

	timeunit 1ns;
	timeprecision 1ps;

	initial clk = 1'b0;

	// Free-running, half a period per phase
	always #(period_ns / 2) clk = ~clk;

endmodule

/* tb_frame_capture.sv */
`include "capture_params.svh"

module tb_frame_capture import video_pkg::*, wb_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int frame_pixels = `FRAME_WIDTH * `FRAME_HEIGHT;
	// Frames sent over the whole run
	localparam int num_frames = 9;

	logic     clk;
	logic     resetn;
	logic     ch0_valid, ch0_user, ch0_last, ch0_ready;
	gray_t    ch0_data;
	logic     ch1_valid, ch1_user, ch1_last, ch1_ready;
	rgb565_t  ch1_data;
	logic     host_cyc, host_stb, host_we, host_ack;
	wb_addr_t host_adr;
	wb_data_t host_dat_w, host_dat_r;
	logic     ch0_frame_done, ch1_frame_done, ch0_line_error, ch1_line_error;

	// Expected memory image and stream position of each channel
	wb_data_t ref_mem [`RAM_DEPTH];
	int col_pos [2] = '{0, 0};
	int line_pos [2] = '{0, 0};
	int sent_last [2] = '{0, 0};
	int done_seen [2] = '{0, 0};

	tb_clock i_clock (.clk(clk));

	frame_capture i_dut (.*);

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped on error");
	endtask

	//////////////////////////////////////////////////
	// Checks on the DUT outputs

	assert property (@(posedge clk) !resetn |=> !(ch0_ready || ch1_ready || host_ack
		|| ch0_frame_done || ch1_frame_done || ch0_line_error || ch1_line_error))
		else abort_run($sformatf("FAILED %0t: outputs active in or after reset", $time));
	assert property (@(posedge clk) disable iff (!resetn) ch0_frame_done |=> !ch0_frame_done)
		else abort_run($sformatf("FAILED %0t: ch0 frame_done wider than a cycle", $time));
	assert property (@(posedge clk) disable iff (!resetn) ch1_frame_done |=> !ch1_frame_done)
		else abort_run($sformatf("FAILED %0t: ch1 frame_done wider than a cycle", $time));
	assert property (@(posedge clk) disable iff (!resetn)
		ch0_frame_done |-> done_seen[0] < sent_last[0])
		else abort_run($sformatf("FAILED %0t: ch0 frame_done before last pixel", $time));
	assert property (@(posedge clk) disable iff (!resetn)
		ch1_frame_done |-> done_seen[1] < sent_last[1])
		else abort_run($sformatf("FAILED %0t: ch1 frame_done before last pixel", $time));
	assert property (@(posedge clk) disable iff (!resetn) host_ack |-> host_cyc && host_stb)
		else abort_run($sformatf("FAILED %0t: host ack without a request", $time));
	assert property (@(posedge clk) disable iff (!resetn) host_ack |=> !host_ack)
		else abort_run($sformatf("FAILED %0t: host access acked twice", $time));

	always @(posedge clk) begin
		if (resetn && ch0_frame_done)
			done_seen[0] <= done_seen[0] + 1;
		if (resetn && ch1_frame_done)
			done_seen[1] <= done_seen[1] + 1;
	end

	initial begin
		repeat (4 * (num_frames * frame_pixels * 8 + 1000)) @(posedge clk);
		abort_run("The run timed out before all tests finished");
	end

	//////////////////////////////////////////////////
	// Stream and host drivers

	task automatic send_pixel(input int ch, input wb_data_t pix, input logic user,
		input logic last);
		logic taken;
		int gap;
		int base;
		gap = ($urandom_range(3) == 0) ? $urandom_range(1, 3) : 0;
		if (ch == 0)
			ch0_valid = 1'b0;
		else
			ch1_valid = 1'b0;
		repeat (gap) begin
			@(posedge clk);
			#2;
		end
		if (ch == 0) begin
			ch0_valid = 1'b1;
			ch0_data  = pix[7:0];
			ch0_user  = user;
			ch0_last  = last;
		end else begin
			ch1_valid = 1'b1;
			ch1_data  = rgb565_t'(pix);
			ch1_user  = user;
			ch1_last  = last;
		end
		// Ready is registered, so its value here decides the next edge
		taken = 1'b0;
		while (!taken) begin
			taken = (ch == 0) ? ch0_ready : ch1_ready;
			@(posedge clk);
			#2;
		end
		base = (ch == 0) ? `CH0_BASE : `CH1_BASE;
		if (user) begin
			col_pos[ch]  = 0;
			line_pos[ch] = 0;
		end
		ref_mem[wb_addr_t'(base + line_pos[ch] * `FRAME_WIDTH + col_pos[ch])] = pix;
		if (last && line_pos[ch] == `FRAME_HEIGHT - 1)
			sent_last[ch]++;
		if (last) begin
			col_pos[ch]  = 0;
			line_pos[ch] = (line_pos[ch] + 1) % `FRAME_HEIGHT;
		end else begin
			col_pos[ch] = (col_pos[ch] + 1) % `FRAME_WIDTH;
		end
	endtask

	// Line short_line ends early and line open_line lacks tlast (-1 for none)
	task automatic send_frame(input int ch, input int short_line, input int open_line);
		int len;
		wb_data_t pix;
		for (int line = 0; line < `FRAME_HEIGHT; line++) begin
			len = (line == short_line) ? `FRAME_WIDTH / 2 : `FRAME_WIDTH;
			for (int col = 0; col < len; col++) begin
				pix = 16'($urandom());
				if (ch == 0)
					pix[15:8] = 8'h00;
				send_pixel(ch, pix, line == 0 && col == 0, col == len - 1 && line != open_line);
			end
		end
		if (ch == 0)
			ch0_valid = 1'b0;
		else
			ch1_valid = 1'b0;
	endtask

	task automatic host_access(input logic write, input wb_addr_t adr, input wb_data_t wdat,
		input bit hold, output wb_data_t rdat);
		logic got_ack;
		got_ack    = 1'b0;
		host_cyc   = 1'b1;
		host_stb   = 1'b1;
		host_we    = write;
		host_adr   = adr;
		host_dat_w = wdat;
		while (!got_ack) begin
			got_ack = host_ack;
			rdat    = host_dat_r;
			@(posedge clk);
			#2;
		end
		host_stb = 1'b0;
		host_we  = 1'b0;
		// Keep the grant a while with no strobe
		if (hold) begin
			repeat ($urandom_range(1, 3)) begin
				@(posedge clk);
				#2;
			end
		end
		host_cyc = 1'b0;
		@(posedge clk);
		#2;
	endtask

	task automatic check_buffer(input int base);
		wb_data_t rdat;
		for (int i = 0; i < frame_pixels; i++) begin
			host_access(1'b0, wb_addr_t'(base + i), '0, 1'b0, rdat);
			assert (rdat == ref_mem[base + i])
				else abort_run($sformatf("FAILED %0t: word %0d read %h, expected %h",
					$time, base + i, rdat, ref_mem[base + i]));
		end
	endtask

	task automatic wait_frames_done();
		while (done_seen[0] != sent_last[0] || done_seen[1] != sent_last[1]) begin
			@(posedge clk);
			#2;
		end
	endtask

	//////////////////////////////////////////////////
	// Test sequence

	initial begin
		wb_data_t rdat;
		wb_data_t wdat;
		wb_addr_t adr;
		void'($urandom(38404));
		resetn     = 1'b0;
		ch0_valid  = 1'b0;
		ch0_data   = '0;
		ch0_user   = 1'b0;
		ch0_last   = 1'b0;
		ch1_valid  = 1'b0;
		ch1_data   = '0;
		ch1_user   = 1'b0;
		ch1_last   = 1'b0;
		host_cyc   = 1'b0;
		host_stb   = 1'b0;
		host_we    = 1'b0;
		host_adr   = '0;
		host_dat_w = '0;
		repeat (10) @(posedge clk);
		#2;
		resetn = 1'b1;
		@(posedge clk);
		#2;

		// One grayscale frame, then read it back
		send_frame(0, -1, -1);
		wait_frames_done();
		check_buffer(`CH0_BASE);

		// Both channels at once while the host competes for the bus
		fork
			repeat (2) send_frame(0, -1, -1);
			repeat (2) send_frame(1, -1, -1);
			repeat (40) host_access(1'b0, wb_addr_t'($urandom_range(`RAM_DEPTH - 1)), '0,
				$urandom_range(1) == 1, rdat);
		join
		wait_frames_done();
		check_buffer(`CH0_BASE);
		check_buffer(`CH1_BASE);

		// Short line on ch0
		send_frame(0, 1, -1);
		while (!ch0_line_error) begin
			@(posedge clk);
			#2;
		end
		assert (!ch1_line_error)
			else abort_run($sformatf("FAILED %0t: ch1 line_error set by ch0", $time));
		wait_frames_done();
		repeat (10) begin
			@(posedge clk);
			#2;
			assert (ch0_line_error)
				else abort_run($sformatf("FAILED %0t: ch0 line_error cleared early", $time));
		end

		// Full line without tlast on ch1
		send_frame(1, -1, 1);
		while (!ch1_line_error) begin
			@(posedge clk);
			#2;
		end
		assert (ch0_line_error)
			else abort_run($sformatf("FAILED %0t: ch0 line_error changed by ch1", $time));
		send_frame(0, -1, -1);
		wait_frames_done();
		assert (!ch0_line_error && ch1_line_error)
			else abort_run($sformatf("FAILED %0t: line_error wrong after ch0 frame", $time));
		send_frame(1, -1, -1);
		wait_frames_done();
		assert (!ch1_line_error)
			else abort_run($sformatf("FAILED %0t: ch1 line_error not cleared", $time));

		// Host write and read back
		repeat (4) begin
			adr  = wb_addr_t'($urandom_range(`RAM_DEPTH - 1));
			wdat = 16'($urandom());
			host_access(1'b1, adr, wdat, 1'b1, rdat);
			host_access(1'b0, adr, '0, 1'b0, rdat);
			assert (rdat == wdat)
				else abort_run($sformatf("FAILED %0t: host read %h at %0d, expected %h",
					$time, rdat, adr, wdat));
		end
		$display("Result: PASSED");
		$finish;
	end

endmodule

/* list.f */
+incdir+.
wb_pkg.sv
video_pkg.sv
axis_relay.sv
frame_writer.sv
wb_arbiter.sv
frame_ram.sv
frame_capture.sv
tb_clock.sv
tb_frame_capture.sv

/* run.sh */
#!/usr/bin/env bash
# Compile and run the frame capture testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_frame_capture -f list.f -o sim_frame_capture
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/sim_frame_capture
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit 1
fi

exit 0
